// ==== src/bbc_mem_pkg.sv ====
package bbc_mem_pkg;

	// widths of the memory bus
	typedef logic [15:0] cpu_addr_t;
	typedef logic [24:0] sdram_addr_t;
	typedef logic [7:0]  romsel_t;
	typedef logic [7:0]  mem_byte_t;

	// core side of the memory slot
	typedef struct packed {
		cpu_addr_t adr;
		romsel_t   romsel;
		logic      acc_y;
		logic      shadow_ram;
		logic      shadow_vid;
		// high for cpu cycle, low for video cycle
		logic      phi0;
		logic      we;
		mem_byte_t dout;
	} cpu_bus_t;

	// request towards the sdram controller
	typedef struct packed {
		sdram_addr_t adr;
		logic        we;
		mem_byte_t   di;
	} sdram_req_t;

	// romsel bit that pages MOS private ram into 8000-8fff
	localparam int unsigned ROMSEL_MOS_RAM = 7;

	// sdram region bases
	localparam sdram_addr_t FILING_RAM_BASE = 25'h0014000;
	localparam sdram_addr_t SWRAM_BASE      = 25'h0040000;
	localparam sdram_addr_t MOS_ROM_BASE    = 25'h0080000;
	localparam sdram_addr_t SWROM_B_BASE    = 25'h0090000;
	localparam sdram_addr_t SWROM_M_BASE    = 25'h00a0000;

	// loader offsets, index 0 is the rom set
	localparam sdram_addr_t LOAD_BASE_ROM   = 25'h0080000;
	localparam sdram_addr_t LOAD_BASE_ALT   = 25'h0068000;

endpackage

// ==== src/bbc_ctrl_pkg.sv ====
package bbc_ctrl_pkg;

	import bbc_mem_pkg::*;

	// OSD machine options
	typedef struct packed {
		// 0 model b, 1 master
		logic model;
		// 1 selects low rom mapping
		logic rommap;
		logic autoboot;
	} machine_cfg_t;

	typedef logic [7:0]  load_index_t;
	typedef logic [24:0] load_addr_t;

	// download port
	typedef struct packed {
		logic        active;
		logic        we;
		load_index_t index;
		load_addr_t  addr;
		mem_byte_t   data;
	} ioctl_t;

	// cmos image, not rom data
	localparam load_index_t CMOS_INDEX = 8'hff;

	typedef enum logic [1:0] {RST_ASSERT, RST_HOLD, RST_RUN} rst_state_e;

endpackage

// ==== src/rom_loader.sv ====
`timescale 1ns/100ps

module rom_loader
	import bbc_mem_pkg::*;
	import bbc_ctrl_pkg::*;
(
	input  logic       clk_48m,
	input  logic       reset,
	input  logic       mem_sync,
	input  ioctl_t     ioctl,
	output sdram_req_t loader_req
);

	logic        pending;
	sdram_addr_t pend_adr;
	mem_byte_t   pend_data;
	logic        req_we;
	sdram_addr_t req_adr;
	mem_byte_t   req_di;
	logic        accept;

	assign accept = ioctl.we && ioctl.active && (ioctl.index != CMOS_INDEX);

	// pending flag and slot strobe
	always_ff @(posedge clk_48m) begin
		if (reset) begin
			pending <= 1'b0;
			req_we  <= 1'b0;
		end else begin
			if (mem_sync) begin
				req_we  <= pending;
				pending <= 1'b0;
			end
			// a write on the mem_sync cycle waits for the next slot
			if (accept)
				pending <= 1'b1;
		end
	end

	// later write in the same slot overwrites the pending one
	always_ff @(posedge clk_48m) begin
		if (accept) begin
			pend_adr  <= sdram_addr_t'(ioctl.addr) +
				((ioctl.index == '0) ? LOAD_BASE_ROM : LOAD_BASE_ALT);
			pend_data <= ioctl.data;
		end
		if (mem_sync && pending) begin
			req_adr <= pend_adr;
			req_di  <= pend_data;
		end
	end

	assign loader_req = '{adr: req_adr, we: req_we, di: req_di};

	a_we_on_slot: assert property (@(posedge clk_48m) disable iff (reset)
		$rose(loader_req.we) |-> $past(mem_sync));

endmodule

// ==== src/sdram_addr_map.sv ====
`timescale 1ns/100ps

module sdram_addr_map
	import bbc_mem_pkg::*;
	import bbc_ctrl_pkg::*;
(
	input  machine_cfg_t cfg,
	input  cpu_bus_t     cpu,
	input  logic         loader_active,
	input  sdram_req_t   loader_req,
	output sdram_req_t   sdram
);

	logic cpu_ram;
	logic mos_rom;
	logic sideways;
	logic mos_ram;
	logic filing_ram;
	logic sideways_ram;
	logic sideways_rom;
	logic page_low;
	logic writable;

	// cpu side regions
	assign cpu_ram    = (cpu.adr[15] == 1'b0);
	assign mos_rom    = (cpu.adr[15:14] == 2'b11);
	assign sideways   = (cpu.adr[15:14] == 2'b10);
	assign mos_ram    = sideways && (cpu.adr[13:12] == 2'b00) && cpu.romsel[ROMSEL_MOS_RAM];
	assign filing_ram = (cpu.adr[15:13] == 3'b110) && cpu.acc_y;

	// sideways ram lives in pages 4 to 7
	assign sideways_ram = sideways && (cpu.romsel[3:2] == 2'b01);

	// master: pages 0-3 and 8-f
	// model b: pages 0-3 in low mapping, c-f in high mapping
	assign page_low = (cpu.romsel[3:2] == 2'b00);
	always_comb begin
		if (cfg.model)
			sideways_rom = sideways && (page_low || cpu.romsel[3]);
		else if (cfg.rommap)
			sideways_rom = sideways && page_low;
		else
			sideways_rom = sideways && (cpu.romsel[3:2] == 2'b11);
	end

	assign writable = cpu_ram || mos_ram || filing_ram || sideways_ram;

	always_comb begin
		if (loader_active)
			sdram.adr = loader_req.adr;
		else if (!cpu.phi0)
			// video fetch
			sdram.adr = sdram_addr_t'({cpu.shadow_vid, cpu.adr});
		else if (cpu_ram || mos_ram)
			sdram.adr = sdram_addr_t'({cpu.shadow_ram, cpu.adr});
		else if (filing_ram)
			sdram.adr = FILING_RAM_BASE + sdram_addr_t'(cpu.adr[12:0]);
		else if (mos_rom)
			// os 1.2 or master mos
			sdram.adr = MOS_ROM_BASE + sdram_addr_t'({cfg.model, cpu.adr[13:0]});
		else if (sideways_rom && !cfg.model)
			sdram.adr = SWROM_B_BASE + sdram_addr_t'({cpu.romsel[1:0], cpu.adr[13:0]});
		else if (sideways_rom)
			sdram.adr = SWROM_M_BASE + sdram_addr_t'({cpu.romsel[3:0], cpu.adr[13:0]});
		else
			sdram.adr = SWRAM_BASE + sdram_addr_t'({cpu.romsel[3:0], cpu.adr[13:0]});
	end

	// rom regions never see a cpu write
	assign sdram.we = loader_active ? loader_req.we : (cpu.we && writable);
	assign sdram.di = loader_active ? loader_req.di : cpu.dout;

	// every cpu write lands below the rom area of the sdram
	a_no_rom_write: assert final (!(sdram.we && !loader_active) ||
		(sdram.adr < MOS_ROM_BASE));

endmodule

// ==== src/reset_sequencer.sv ====
`timescale 1ns/100ps

module reset_sequencer
	import bbc_ctrl_pkg::*;
#(
	parameter int unsigned REMAP_HOLD_CYCLES = 4095
) (
	input  logic         clk_48m,
	input  logic         reset,
	input  logic         mem_sync,
	input  machine_cfg_t cfg,
	input  logic         sys_ready,
	input  logic         reset_request,
	input  logic         loader_active,
	output logic         core_reset
);

	localparam int unsigned HOLD_W = $clog2(REMAP_HOLD_CYCLES + 1);

	rst_state_e        state;
	rst_state_e        state_next;
	logic              last_model;
	logic              last_rommap;
	logic [HOLD_W-1:0] hold_cnt;
	logic              hold_active;
	logic              ext_src;

	assign ext_src     = !sys_ready || reset_request || loader_active;
	assign hold_active = (hold_cnt != '0);

	// reset the core for a while when model or rom map changes
	always_ff @(posedge clk_48m) begin
		if (reset) begin
			last_model  <= cfg.model;
			last_rommap <= cfg.rommap;
			hold_cnt    <= '0;
		end else begin
			last_model  <= cfg.model;
			last_rommap <= cfg.rommap;
			if (last_model != cfg.model || last_rommap != cfg.rommap)
				hold_cnt <= HOLD_W'(REMAP_HOLD_CYCLES);
			else if (hold_active)
				hold_cnt <= hold_cnt - 1'b1;
		end
	end

	always_comb begin
		state_next = state;
		case (state)
			RST_ASSERT:
				if (!ext_src)
					state_next = hold_active ? RST_HOLD : RST_RUN;
			RST_HOLD:
				if (ext_src)
					state_next = RST_ASSERT;
				else if (!hold_active)
					state_next = RST_RUN;
			default:
				if (ext_src)
					state_next = RST_ASSERT;
				else if (hold_active)
					state_next = RST_HOLD;
		endcase
	end

	// state moves with the memory slot
	always_ff @(posedge clk_48m) begin
		if (reset) begin
			state      <= RST_ASSERT;
			core_reset <= 1'b1;
		end else if (mem_sync) begin
			state      <= state_next;
			core_reset <= (state_next != RST_RUN);
		end
	end

	a_reset_on_slot: assert property (@(posedge clk_48m) disable iff (reset)
		$changed(core_reset) |-> $past(mem_sync));

endmodule

// ==== src/autoboot_timer.sv ====
`timescale 1ns/100ps

module autoboot_timer #(
	parameter int unsigned AUTOBOOT_CYCLES = 32_000_000
) (
	input  logic clk_48m,
	input  logic reset,
	input  logic core_reset,
	input  logic autoboot,
	output logic autoboot_shift
);

	localparam int unsigned CNT_W = $clog2(AUTOBOOT_CYCLES + 1);

	logic [CNT_W-1:0] boot_cnt;

	// reload while the core sits in reset, then run down
	always_ff @(posedge clk_48m) begin
		if (reset || core_reset)
			boot_cnt <= CNT_W'(AUTOBOOT_CYCLES);
		else if (boot_cnt != '0)
			boot_cnt <= boot_cnt - 1'b1;
	end

	// shift held down so the mos boots from disc
	assign autoboot_shift = autoboot && (boot_cnt != '0);

endmodule

// ==== src/bbc_mem_top.sv ====
`timescale 1ns/100ps

module bbc_mem_top
	import bbc_mem_pkg::*;
	import bbc_ctrl_pkg::*;
#(
	parameter int unsigned REMAP_HOLD_CYCLES = 4095,
	parameter int unsigned AUTOBOOT_CYCLES   = 32_000_000
) (
	input  logic         clk_48m,
	input  logic         reset,
	input  logic         mem_sync,
	input  machine_cfg_t cfg,
	input  cpu_bus_t     cpu,
	input  ioctl_t       ioctl,
	input  logic         sys_ready,
	input  logic         reset_request,
	output sdram_req_t   sdram,
	output logic         core_reset,
	output logic         autoboot_shift
);

	sdram_req_t loader_req;

	rom_loader i_rom_loader (
		.clk_48m    (clk_48m),
		.reset      (reset),
		.mem_sync   (mem_sync),
		.ioctl      (ioctl),
		.loader_req (loader_req)
	);

	// loader owns the bus for the whole download
	sdram_addr_map i_sdram_addr_map (
		.cfg           (cfg),
		.cpu           (cpu),
		.loader_active (ioctl.active),
		.loader_req    (loader_req),
		.sdram         (sdram)
	);

	reset_sequencer #(
		.REMAP_HOLD_CYCLES (REMAP_HOLD_CYCLES)
	) i_reset_sequencer (
		.clk_48m       (clk_48m),
		.reset         (reset),
		.mem_sync      (mem_sync),
		.cfg           (cfg),
		.sys_ready     (sys_ready),
		.reset_request (reset_request),
		.loader_active (ioctl.active),
		.core_reset    (core_reset)
	);

	autoboot_timer #(
		.AUTOBOOT_CYCLES (AUTOBOOT_CYCLES)
	) i_autoboot_timer (
		.clk_48m        (clk_48m),
		.reset          (reset),
		.core_reset     (core_reset),
		.autoboot       (cfg.autoboot),
		.autoboot_shift (autoboot_shift)
	);

endmodule

// ==== tests/tb_bbc_mem_top.sv ====
`timescale 1ns/100ps

module tb_bbc_mem_top
	import bbc_mem_pkg::*;
	import bbc_ctrl_pkg::*;
();

	localparam int REMAP_HOLD = 20;
	localparam int AUTOBOOT = 60;
	localparam int SLOT = 8;
	localparam int N_ROWS = 20;
	localparam int LIMIT_CYCLES = N_ROWS * 200 + REMAP_HOLD + AUTOBOOT;
	localparam int SIG_RESET = 0;
	localparam int SIG_WE = 1;

	// one address map case, low 12 address bits come from the rng
	typedef struct packed {
		logic        model;
		logic        rommap;
		logic        phi0;
		logic        we;
		logic        acc_y;
		logic        mos_ram;
		logic        shadow_ram;
		logic        shadow_vid;
		logic [3:0]  adr_hi;
		logic [3:0]  page;
		sdram_addr_t exp_adr;
		logic        exp_we;
	} map_row_t;

	logic         clk_48m;
	logic         reset;
	logic         mem_sync;
	machine_cfg_t cfg;
	cpu_bus_t     cpu;
	ioctl_t       ioctl;
	logic         sys_ready;
	logic         reset_request;
	sdram_req_t   sdram;
	logic         core_reset;
	logic         autoboot_shift;

	map_row_t     map_tab [N_ROWS];
	logic [2:0]   slot_cnt;
	logic [31:0]  rng;
	int           cycles;
	logic         mon_on;
	logic         rst_seen;
	logic         sync_seen;

	bbc_mem_top #(
		.REMAP_HOLD_CYCLES (REMAP_HOLD),
		.AUTOBOOT_CYCLES   (AUTOBOOT)
	) i_dut (
		.clk_48m        (clk_48m),
		.reset          (reset),
		.mem_sync       (mem_sync),
		.cfg            (cfg),
		.cpu            (cpu),
		.ioctl          (ioctl),
		.sys_ready      (sys_ready),
		.reset_request  (reset_request),
		.sdram          (sdram),
		.core_reset     (core_reset),
		.autoboot_shift (autoboot_shift)
	);

	always #10 clk_48m = ~clk_48m;

	// memory slot strobe, one cycle in eight
	always @(posedge clk_48m) begin
		#2;
		slot_cnt = slot_cnt + 1'b1;
		mem_sync = (slot_cnt == 3'd7);
	end

	always @(posedge clk_48m) begin
		cycles++;
		if (cycles >= LIMIT_CYCLES) begin
			$display("run did not finish within %0d cycles", LIMIT_CYCLES);
			abort_run();
		end
	end

	// core_reset may only move on the edge that closes a mem_sync cycle
	always @(negedge clk_48m) begin
		if (mon_on && core_reset !== rst_seen && !sync_seen) begin
			$display("core_reset changed in a cycle that did not follow mem_sync");
			abort_run();
		end
		rst_seen = core_reset;
		sync_seen = mem_sync;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	task automatic abort_run();
		$display("sim failed");
		$fatal(1);
	endtask

	task automatic check_sdram_addr(input string name, input sdram_addr_t exp,
		input sdram_addr_t act);
		if (act !== exp) begin
			$display("ERROR %s: expected %h, actual %h", name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_byte(input string name, input mem_byte_t exp, input mem_byte_t act);
		if (act !== exp) begin
			$display("ERROR %s: expected %h, actual %h", name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("ERROR %s: expected %b, actual %b", name, exp, act);
			abort_run();
		end
	endtask

	task automatic step();
		@(posedge clk_48m);
		#2;
	endtask

	// returns on the falling edge where the signal first shows the level
	task automatic wait_level(input int sig, input logic level, input int max_cycles,
		input string name);
		int n;
		n = 0;
		@(negedge clk_48m);
		while (((sig == SIG_RESET) ? core_reset : sdram.we) !== level) begin
			if (n >= max_cycles) begin
				$display("%s: signal did not reach %b within %0d cycles", name, level,
					max_cycles);
				abort_run();
			end
			n++;
			@(negedge clk_48m);
		end
	endtask

	task automatic send_write(input load_index_t index, input load_addr_t addr,
		input mem_byte_t data);
		step();
		ioctl.we = 1'b1;
		ioctl.index = index;
		ioctl.addr = addr;
		ioctl.data = data;
		step();
		ioctl.we = 1'b0;
	endtask

	task automatic drive_source(input int src, input logic on);
		case (src)
			0: reset_request = on;
			1: sys_ready = !on;
			default: ioctl.active = on;
		endcase
	endtask

	task automatic check_source(input int src, input string name);
		step();
		drive_source(src, 1'b1);
		wait_level(SIG_RESET, 1'b1, SLOT + 2, name);
		step();
		drive_source(src, 1'b0);
		wait_level(SIG_RESET, 1'b0, SLOT + 2, name);
	endtask

	// caller has just flipped model or rommap
	task automatic check_hold(input string name);
		int k;
		k = 0;
		@(negedge clk_48m);
		while (core_reset !== 1'b1 && k < SLOT + 2) begin
			k++;
			@(negedge clk_48m);
		end
		check_bit(name, 1'b1, core_reset);
		while (k < REMAP_HOLD) begin
			check_bit(name, 1'b1, core_reset);
			k++;
			@(negedge clk_48m);
		end
		wait_level(SIG_RESET, 1'b0, SLOT + 2, name);
	endtask

	// model rommap phi0 we acc_y mos shr shv adr_hi page exp_adr exp_we
	initial begin
		map_tab[0]  = '{0, 0, 1, 1, 0, 0, 0, 0, 4'h3, 4'h0, 25'h0003000, 1};
		map_tab[1]  = '{1, 0, 1, 1, 0, 0, 1, 0, 4'h3, 4'h0, 25'h0013000, 1};
		map_tab[2]  = '{0, 0, 0, 0, 0, 0, 0, 1, 4'h5, 4'h0, 25'h0015000, 0};
		map_tab[3]  = '{1, 1, 0, 0, 0, 0, 1, 0, 4'hc, 4'h0, 25'h000c000, 0};
		map_tab[4]  = '{1, 0, 1, 1, 0, 1, 1, 0, 4'h8, 4'h5, 25'h0018000, 1};
		map_tab[5]  = '{0, 0, 1, 1, 0, 1, 0, 0, 4'h8, 4'hc, 25'h0008000, 1};
		map_tab[6]  = '{0, 0, 1, 1, 0, 0, 0, 0, 4'hc, 4'h0, 25'h0080000, 0};
		map_tab[7]  = '{1, 0, 1, 1, 0, 0, 0, 0, 4'hf, 4'h0, 25'h0087000, 0};
		map_tab[8]  = '{1, 1, 1, 1, 0, 0, 0, 0, 4'he, 4'h0, 25'h0086000, 0};
		map_tab[9]  = '{1, 0, 1, 1, 1, 0, 0, 0, 4'hd, 4'h0, 25'h0015000, 1};
		map_tab[10] = '{0, 1, 1, 1, 1, 0, 0, 0, 4'hc, 4'h0, 25'h0014000, 1};
		map_tab[11] = '{0, 0, 1, 1, 0, 0, 0, 0, 4'h8, 4'hd, 25'h0094000, 0};
		map_tab[12] = '{0, 1, 1, 1, 0, 0, 0, 0, 4'ha, 4'h2, 25'h009a000, 0};
		map_tab[13] = '{0, 0, 1, 1, 0, 0, 0, 0, 4'ha, 4'h2, 25'h004a000, 0};
		map_tab[14] = '{0, 1, 1, 1, 0, 0, 0, 0, 4'h8, 4'he, 25'h0078000, 0};
		map_tab[15] = '{1, 0, 1, 1, 0, 0, 0, 0, 4'hb, 4'h9, 25'h00c7000, 0};
		map_tab[16] = '{1, 1, 1, 1, 0, 0, 0, 0, 4'h9, 4'h1, 25'h00a5000, 0};
		map_tab[17] = '{0, 0, 1, 1, 0, 0, 0, 0, 4'h9, 4'h4, 25'h0051000, 1};
		map_tab[18] = '{1, 0, 1, 1, 0, 0, 0, 0, 4'hb, 4'h7, 25'h005f000, 1};
		map_tab[19] = '{0, 1, 1, 1, 0, 0, 0, 0, 4'h8, 4'h6, 25'h0058000, 1};
	end

	initial begin
		map_row_t cur;
		string    name;
		clk_48m = 1'b0;
		reset = 1'b1;
		mem_sync = 1'b0;
		slot_cnt = 3'd0;
		cfg = '{model: 1'b0, rommap: 1'b0, autoboot: 1'b1};
		cpu = '0;
		ioctl = '0;
		sys_ready = 1'b1;
		reset_request = 1'b0;
		rng = 32'hee0a;
		cycles = 0;
		mon_on = 1'b0;
		rst_seen = 1'b1;
		sync_seen = 1'b0;
		repeat (10) @(posedge clk_48m);
		#2;
		reset = 1'b0;
		mon_on = 1'b1;
		@(negedge clk_48m);
		check_bit("after reset", 1'b1, core_reset);
		check_bit("after reset", 1'b1, autoboot_shift);

		// shift held for the full count once the core leaves reset
		wait_level(SIG_RESET, 1'b0, SLOT + 2, "reset release");
		for (int k = 0; k < AUTOBOOT; k++) begin
			check_bit("autoboot on", 1'b1, autoboot_shift);
			@(negedge clk_48m);
		end
		check_bit("autoboot on", 1'b0, autoboot_shift);

		for (int i = 0; i < N_ROWS; i++) begin
			cur = map_tab[i];
			rng = xorshift32(rng);
			step();
			cfg.model = cur.model;
			cfg.rommap = cur.rommap;
			cpu.adr = {cur.adr_hi, rng[11:0]};
			cpu.romsel = {cur.mos_ram, rng[14:12], cur.page};
			cpu.acc_y = cur.acc_y;
			cpu.shadow_ram = cur.shadow_ram;
			cpu.shadow_vid = cur.shadow_vid;
			cpu.phi0 = cur.phi0;
			cpu.we = cur.we;
			cpu.dout = rng[23:16];
			@(negedge clk_48m);
			name = $sformatf("map row %0d", i);
			check_sdram_addr(name, cur.exp_adr | sdram_addr_t'(rng[11:0]), sdram.adr);
			check_bit(name, cur.exp_we, sdram.we);
			check_byte(name, mem_byte_t'(rng[23:16]), sdram.di);
		end
		wait_level(SIG_RESET, 1'b0, REMAP_HOLD + 3 * SLOT, "map table hold");

		// download with a cpu write to main ram pending on the bus
		step();
		cpu = '0;
		cpu.adr = 16'h0100;
		cpu.phi0 = 1'b1;
		cpu.we = 1'b1;
		cpu.dout = 8'h11;
		ioctl.active = 1'b1;
		@(negedge clk_48m);
		check_bit("download masks cpu", 1'b0, sdram.we);
		send_write(8'h00, 25'h0001234, 8'h5a);
		wait_level(SIG_WE, 1'b1, 2 * SLOT, "download index 0");
		check_sdram_addr("download index 0", 25'h0081234, sdram.adr);
		check_byte("download index 0", 8'h5a, sdram.di);
		wait_level(SIG_WE, 1'b0, SLOT + 2, "download index 0");
		send_write(8'h01, 25'h0000100, 8'hc3);
		wait_level(SIG_WE, 1'b1, 2 * SLOT, "download index 1");
		check_sdram_addr("download index 1", 25'h0068100, sdram.adr);
		check_byte("download index 1", 8'hc3, sdram.di);
		wait_level(SIG_WE, 1'b0, SLOT + 2, "download index 1");
		send_write(8'hff, 25'h0000010, 8'h77);
		for (int k = 0; k < 3 * SLOT; k++) begin
			@(negedge clk_48m);
			check_bit("cmos index", 1'b0, sdram.we);
		end
		step();
		ioctl.active = 1'b0;
		cpu.we = 1'b0;
		wait_level(SIG_RESET, 1'b0, SLOT + 2, "download end");

		check_source(0, "reset_request");
		check_source(1, "sys_ready low");
		check_source(2, "download active");

		step();
		cfg.model = ~cfg.model;
		check_hold("model change");
		step();
		cfg.rommap = ~cfg.rommap;
		check_hold("rommap change");

		step();
		cfg.autoboot = 1'b0;
		check_source(0, "autoboot off");
		for (int k = 0; k < AUTOBOOT + SLOT; k++) begin
			check_bit("autoboot off", 1'b0, autoboot_shift);
			@(negedge clk_48m);
		end

		$display("sim passed");
		$finish;
	end

endmodule

// ==== all.f ====
src/bbc_mem_pkg.sv
src/bbc_ctrl_pkg.sv
src/rom_loader.sv
src/sdram_addr_map.sv
src/reset_sequencer.sv
src/autoboot_timer.sv
src/bbc_mem_top.sv
tests/tb_bbc_mem_top.sv

// ==== Bender.yml ====
package:
  name: bbc_mem

sources:
  - files:
      - src/bbc_mem_pkg.sv
      - src/bbc_ctrl_pkg.sv
      - src/rom_loader.sv
      - src/sdram_addr_map.sv
      - src/reset_sequencer.sv
      - src/autoboot_timer.sv
      - src/bbc_mem_top.sv
  - target: test
    files:
      - tests/tb_bbc_mem_top.sv
